// File: include/sram_axil_defs.svh
`ifndef SRAM_AXIL_DEFS_SVH
`define SRAM_AXIL_DEFS_SVH

// AXI4-Lite response codes
`define resp_okay   2'b00
`define resp_slverr 2'b10

`endif

// File: logic/sram_pkg.sv
`default_nettype none

package sram_pkg;

  // sram chip geometry
  localparam int sram_addr_w = 8;
  localparam int sram_data_w = 16;

  // axi4-lite side
  localparam int axil_addr_w = 32;
  localparam int axil_data_w = 32;
  localparam int axil_strb_w = axil_data_w / 8;

  // metadata fifo, also the limit on requests in flight
  localparam int meta_fifo_depth_log2 = 2;
  localparam logic [meta_fifo_depth_log2:0] meta_fifo_depth =
    {1'b1, {meta_fifo_depth_log2{1'b0}}};

  // one sram access, as issued by the bridge
  typedef struct packed {
    logic                   is_write;
    logic [sram_addr_w-1:0] addr;
    logic [sram_data_w-1:0] wdata;
  } sram_cmd_t;

  // what the response needs to know about an access
  typedef struct packed {
    logic is_write;
    logic err;
  } sram_meta_t;

  typedef struct packed {
    sram_meta_t             meta;
    logic [sram_data_w-1:0] rdata;
  } sram_rsp_t;

endpackage

`default_nettype wire

// File: logic/axil_sram_bridge.sv
`default_nettype none

`include "sram_axil_defs.svh"

module axil_sram_bridge (
  input  logic                             clk,
  input  logic                             rst_n,

  input  logic                             awvalid,
  output logic                             awready,
  input  logic [sram_pkg::axil_addr_w-1:0] awaddr,
  input  logic                             wvalid,
  output logic                             wready,
  input  logic [sram_pkg::axil_data_w-1:0] wdata,
  input  logic [sram_pkg::axil_strb_w-1:0] wstrb,
  output logic                             bvalid,
  input  logic                             bready,
  output logic [1:0]                       bresp,
  input  logic                             arvalid,
  output logic                             arready,
  input  logic [sram_pkg::axil_addr_w-1:0] araddr,
  output logic                             rvalid,
  input  logic                             rready,
  output logic [sram_pkg::axil_data_w-1:0] rdata,
  output logic [1:0]                       rresp,

  output logic                             cmd_valid,
  input  logic                             cmd_ready,
  output sram_pkg::sram_cmd_t              cmd,
  output sram_pkg::sram_meta_t             cmd_meta,
  input  logic                             rsp_valid,
  output logic                             rsp_ready,
  input  sram_pkg::sram_rsp_t              rsp
);

  logic                                    wr_pair;
  logic                                    slot_free;
  logic                                    room;
  logic                                    take_wr;
  logic                                    take_rd;
  logic                                    wr_err;
  logic                                    rd_err;
  logic                                    rsp_fire;
  logic                                    b_done;
  logic                                    r_done;
  logic [sram_pkg::meta_fifo_depth_log2:0] inflight;

  assign wr_pair   = awvalid && wvalid;
  assign slot_free = !cmd_valid || cmd_ready;
  assign room      = inflight < sram_pkg::meta_fifo_depth;

  // writes win ties, a read only goes when no write pair is waiting
  assign take_wr = wr_pair && slot_free && room;
  assign take_rd = arvalid && !wr_pair && slot_free && room;

  assign awready = take_wr;
  assign wready  = take_wr;
  assign arready = take_rd;

  // outside the 512 byte window, or a strobe missing one of the low bytes
  assign wr_err = (|awaddr[sram_pkg::axil_addr_w-1:sram_pkg::sram_addr_w+1]) ||
                  !(&wstrb[sram_pkg::sram_data_w/8-1:0]);
  assign rd_err = |araddr[sram_pkg::axil_addr_w-1:sram_pkg::sram_addr_w+1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cmd_valid <= 1'b0;
    end else if (take_wr || take_rd) begin
      cmd_valid <= 1'b1;
    end else if (cmd_ready) begin
      cmd_valid <= 1'b0;
    end
  end

  // a rejected write becomes a read of the same word, so order holds
  always_ff @(posedge clk) begin
    if (take_wr) begin
      cmd.is_write      <= !wr_err;
      cmd.addr          <= awaddr[sram_pkg::sram_addr_w:1];
      cmd.wdata         <= wdata[sram_pkg::sram_data_w-1:0];
      cmd_meta.is_write <= 1'b1;
      cmd_meta.err      <= wr_err;
    end else if (take_rd) begin
      cmd.is_write      <= 1'b0;
      cmd.addr          <= araddr[sram_pkg::sram_addr_w:1];
      cmd.wdata         <= '0;
      cmd_meta.is_write <= 1'b0;
      cmd_meta.err      <= rd_err;
    end
  end

  // steer each response to its channel
  assign rsp_ready = rsp.meta.is_write ? (!bvalid || bready) : (!rvalid || rready);
  assign rsp_fire  = rsp_valid && rsp_ready;
  assign b_done    = bvalid && bready;
  assign r_done    = rvalid && rready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      if (rsp_fire && rsp.meta.is_write) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (rsp_fire && !rsp.meta.is_write) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_fire && rsp.meta.is_write) begin
      bresp <= rsp.meta.err ? `resp_slverr : `resp_okay;
    end
    if (rsp_fire && !rsp.meta.is_write) begin
      rresp <= rsp.meta.err ? `resp_slverr : `resp_okay;
      // upper half reads as zero
      rdata <= rsp.meta.err ? '0 :
               {{(sram_pkg::axil_data_w - sram_pkg::sram_data_w){1'b0}}, rsp.rdata};
    end
  end

  // requests between AR/AW acceptance and the B/R handshake
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      inflight <= '0;
    end else begin
      inflight <= inflight
                  + {{sram_pkg::meta_fifo_depth_log2{1'b0}}, take_wr || take_rd}
                  - {{sram_pkg::meta_fifo_depth_log2{1'b0}}, b_done}
                  - {{sram_pkg::meta_fifo_depth_log2{1'b0}}, r_done};
    end
  end

  cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd) && $stable(cmd_meta));

endmodule

`default_nettype wire

// File: logic/sram_meta_fifo.sv
`default_nettype none

module sram_meta_fifo (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 push,
  input  sram_pkg::sram_meta_t push_meta,
  input  logic                 pop,
  output sram_pkg::sram_meta_t pop_meta,
  output logic                 full,
  output logic                 empty
);

  sram_pkg::sram_meta_t                      mem[sram_pkg::meta_fifo_depth];
  logic [sram_pkg::meta_fifo_depth_log2-1:0] wr_ptr;
  logic [sram_pkg::meta_fifo_depth_log2-1:0] rd_ptr;
  logic [sram_pkg::meta_fifo_depth_log2:0]   count;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + {{(sram_pkg::meta_fifo_depth_log2-1){1'b0}}, 1'b1};
      end
      if (pop) begin
        rd_ptr <= rd_ptr + {{(sram_pkg::meta_fifo_depth_log2-1){1'b0}}, 1'b1};
      end
      if (push && !pop) begin
        count <= count + {{sram_pkg::meta_fifo_depth_log2{1'b0}}, 1'b1};
      end else if (pop && !push) begin
        count <= count - {{sram_pkg::meta_fifo_depth_log2{1'b0}}, 1'b1};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_meta;
    end
  end

  // head of the queue, oldest access still unanswered
  assign pop_meta = mem[rd_ptr];
  assign full     = count == sram_pkg::meta_fifo_depth;
  assign empty    = count == '0;

  no_overflow: assert property (@(posedge clk) disable iff (!rst_n) !(push && full));
  no_underflow: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty));

endmodule

`default_nettype wire

// File: logic/sram_cmd_ctrl.sv
`default_nettype none

module sram_cmd_ctrl (
  input  logic                             clk,
  input  logic                             rst_n,

  input  logic                             cmd_valid,
  output logic                             cmd_ready,
  input  sram_pkg::sram_cmd_t              cmd,
  input  sram_pkg::sram_meta_t             cmd_meta,

  output logic                             rsp_valid,
  input  logic                             rsp_ready,
  output sram_pkg::sram_rsp_t              rsp,

  output logic                             pad_start,
  output logic                             pad_is_write,
  output logic [sram_pkg::sram_addr_w-1:0] pad_addr,
  output logic [sram_pkg::sram_data_w-1:0] pad_wdata,
  input  logic                             pad_done,
  input  logic [sram_pkg::sram_data_w-1:0] pad_rdata
);

  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_write
  } state_t;

  state_t                           state;
  logic                             accept;
  logic                             rsp_free;
  logic                             result_wait;
  logic                             held_valid;
  logic [sram_pkg::sram_data_w-1:0] held_rdata;
  logic [sram_pkg::sram_data_w-1:0] rsp_rdata;
  logic                             fifo_pop;
  logic                             fifo_full;
  logic                             fifo_empty;
  sram_pkg::sram_meta_t             head_meta;

  sram_meta_fifo meta_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (accept),
    .push_meta(cmd_meta),
    .pop      (fifo_pop),
    .pop_meta (head_meta),
    .full     (fifo_full),
    .empty    (fifo_empty)
  );

  assign rsp_free = !rsp_valid || rsp_ready;

  // a finished result with nowhere to go blocks the next access
  assign result_wait = held_valid || (pad_done && !rsp_free);

  assign cmd_ready = (state == st_idle) && !fifo_full && !result_wait;
  assign accept    = cmd_valid && cmd_ready;

  assign pad_start    = accept;
  assign pad_is_write = cmd.is_write;
  assign pad_addr     = cmd.addr;
  assign pad_wdata    = cmd.wdata;

  // one strobe cycle per access, then back to idle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle:  state <= accept ? (cmd.is_write ? st_write : st_read) : st_idle;
        st_read:  state <= st_idle;
        st_write: state <= st_idle;
        default:  state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_valid  <= 1'b0;
      held_valid <= 1'b0;
    end else begin
      if (rsp_free) begin
        rsp_valid <= held_valid || pad_done;
      end
      if (pad_done && !rsp_free) begin
        held_valid <= 1'b1;
      end else if (rsp_free) begin
        held_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_free) begin
      rsp_rdata <= held_valid ? held_rdata : pad_rdata;
    end
    if (pad_done && !rsp_free) begin
      held_rdata <= pad_rdata;
    end
  end

  // metadata stays at the fifo head until its response goes out
  assign fifo_pop   = rsp_valid && rsp_ready;
  assign rsp.meta   = head_meta;
  assign rsp.rdata  = rsp_rdata;

  done_has_meta: assert property (@(posedge clk) disable iff (!rst_n)
    pad_done |-> !fifo_empty);

  rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

`default_nettype wire

// File: logic/sram_pad_io.sv
`default_nettype none

module sram_pad_io (
  input  logic                             clk,
  input  logic                             rst_n,

  input  logic                             start,
  input  logic                             is_write,
  input  logic [sram_pkg::sram_addr_w-1:0] addr,
  input  logic [sram_pkg::sram_data_w-1:0] wdata,
  output logic                             done,
  output logic [sram_pkg::sram_data_w-1:0] rdata,

  output logic [sram_pkg::sram_addr_w-1:0] sram_addr,
  inout  wire  [sram_pkg::sram_data_w-1:0] sram_data,
  output logic                             sram_we_n,
  output logic                             sram_oe_n,
  output logic                             sram_ce_n
);

  logic [sram_pkg::sram_data_w-1:0] wdata_q;

  // chip stays selected, the strobes do the work
  assign sram_ce_n = 1'b0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sram_we_n <= 1'b1;
      sram_oe_n <= 1'b1;
      done      <= 1'b0;
    end else begin
      sram_we_n <= !(start && is_write);
      sram_oe_n <= !(start && !is_write);
      // strobe cycle just ended
      done      <= !sram_we_n || !sram_oe_n;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      sram_addr <= addr;
    end
    if (start && is_write) begin
      wdata_q <= wdata;
    end
    // sample at the end of the read strobe
    if (!sram_oe_n) begin
      rdata <= sram_data;
    end
  end

  // bus driven only while the write strobe is low
  assign sram_data = sram_we_n ? {sram_pkg::sram_data_w{1'bz}} : wdata_q;

  // the controller must leave a gap between accesses
  one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    !sram_we_n || !sram_oe_n |=> sram_we_n && sram_oe_n);

endmodule

`default_nettype wire

// File: logic/sram_axil_top.sv
`default_nettype none

module sram_axil_top (
  input  logic                             clk,
  input  logic                             rst_n,

  input  logic                             awvalid,
  output logic                             awready,
  input  logic [sram_pkg::axil_addr_w-1:0] awaddr,
  input  logic                             wvalid,
  output logic                             wready,
  input  logic [sram_pkg::axil_data_w-1:0] wdata,
  input  logic [sram_pkg::axil_strb_w-1:0] wstrb,
  output logic                             bvalid,
  input  logic                             bready,
  output logic [1:0]                       bresp,
  input  logic                             arvalid,
  output logic                             arready,
  input  logic [sram_pkg::axil_addr_w-1:0] araddr,
  output logic                             rvalid,
  input  logic                             rready,
  output logic [sram_pkg::axil_data_w-1:0] rdata,
  output logic [1:0]                       rresp,

  output logic [sram_pkg::sram_addr_w-1:0] sram_addr,
  inout  wire  [sram_pkg::sram_data_w-1:0] sram_data,
  output logic                             sram_we_n,
  output logic                             sram_oe_n,
  output logic                             sram_ce_n
);

  logic                             cmd_valid;
  logic                             cmd_ready;
  sram_pkg::sram_cmd_t              cmd;
  sram_pkg::sram_meta_t             cmd_meta;
  logic                             rsp_valid;
  logic                             rsp_ready;
  sram_pkg::sram_rsp_t              rsp;
  logic                             pad_start;
  logic                             pad_is_write;
  logic [sram_pkg::sram_addr_w-1:0] pad_addr;
  logic [sram_pkg::sram_data_w-1:0] pad_wdata;
  logic                             pad_done;
  logic [sram_pkg::sram_data_w-1:0] pad_rdata;

  axil_sram_bridge bridge (.*);

  sram_cmd_ctrl ctrl (.*);

  sram_pad_io pad (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (pad_start),
    .is_write (pad_is_write),
    .addr     (pad_addr),
    .wdata    (pad_wdata),
    .done     (pad_done),
    .rdata    (pad_rdata),
    .sram_addr(sram_addr),
    .sram_data(sram_data),
    .sram_we_n(sram_we_n),
    .sram_oe_n(sram_oe_n),
    .sram_ce_n(sram_ce_n)
  );

endmodule

`default_nettype wire

// File: sim/async_sram_model.sv
`default_nettype none

module async_sram_model (
  input  wire [sram_pkg::sram_addr_w-1:0] addr,
  inout  wire [sram_pkg::sram_data_w-1:0] data,
  input  wire                             we_n,
  input  wire                             oe_n,
  input  wire                             ce_n
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [sram_pkg::sram_data_w-1:0] mem [2**sram_pkg::sram_addr_w];

  // output enable puts the word on the bus, write enable overrides it
  assign data = (!ce_n && !oe_n && we_n) ? mem[addr] : {sram_pkg::sram_data_w{1'bz}};

  // write lands inside the strobe once the registered pins have settled
  always @(negedge we_n) begin
    #1;
    if (!ce_n && !we_n) begin
      mem[addr] = data;
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_sram_axil.sv
`default_nettype none

`include "sram_axil_defs.svh"

module tb_sram_axil;
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic [1:0]  resp;
    logic [31:0] data;
  } beat_t;

  logic        clk;
  logic        rst_n;
  logic        awvalid;
  logic        awready;
  logic [31:0] awaddr;
  logic        wvalid;
  logic        wready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        bvalid;
  logic        bready;
  logic [1:0]  bresp;
  logic        arvalid;
  logic        arready;
  logic [31:0] araddr;
  logic        rvalid;
  logic        rready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic [7:0]  sram_addr;
  wire  [15:0] sram_data;
  logic        sram_we_n;
  logic        sram_oe_n;
  logic        sram_ce_n;

  logic [15:0] ref_mem [256];
  beat_t       exp_b[$];
  beat_t       exp_r[$];
  integer      seed;
  integer      ready_seed;
  logic        stall;
  int          checks;
  int          errors;

  sram_axil_top uut (.*);

  async_sram_model sram (
    .addr(sram_addr),
    .data(sram_data),
    .we_n(sram_we_n),
    .oe_n(sram_oe_n),
    .ce_n(sram_ce_n)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // expected response for one request, applied to the reference memory in issue order
  function automatic beat_t reference_access(input logic is_write, input logic [31:0] addr,
                                             input logic [31:0] data, input logic [3:0] strb);
    beat_t beat;
    logic  err;
    err = addr[31:9] != 23'd0;
    if (is_write && strb[1:0] != 2'b11) begin
      err = 1'b1;
    end
    beat.resp = err ? `resp_slverr : `resp_okay;
    beat.data = 32'd0;
    if (!err && is_write) begin
      ref_mem[addr[8:1]] = data[15:0];
    end else if (!err) begin
      beat.data = {16'd0, ref_mem[addr[8:1]]};
    end
    return beat;
  endfunction

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("TESTS FAILED");
    $finish;
  endtask

  task automatic report_test(input string name, input int mark);
    if (errors == mark) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - mark);
    end
  endtask

  task automatic check_b_beat();
    beat_t exp;
    checks++;
    assert (exp_b.size() != 0) else begin
      errors++;
      $display("write response at %0t with no write outstanding", $time);
    end
    if (exp_b.size() != 0) begin
      exp = exp_b.pop_front();
      check_word("bresp", {30'd0, bresp}, {30'd0, exp.resp});
    end
  endtask

  task automatic check_r_beat();
    beat_t exp;
    checks++;
    assert (exp_r.size() != 0) else begin
      errors++;
      $display("read response at %0t with no read outstanding", $time);
    end
    if (exp_r.size() != 0) begin
      exp = exp_r.pop_front();
      check_word("rresp", {30'd0, rresp}, {30'd0, exp.resp});
      check_word("rdata", rdata, exp.data);
    end
  endtask

  // called on a falling edge, returns on the falling edge after the handshake
  task automatic send_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    int waited;
    waited = 0;
    awaddr = addr;
    wdata = data;
    wstrb = strb;
    awvalid = 1'b1;
    wvalid = 1'b1;
    #1;
    while (!(awready && wready)) begin
      if (waited == 200) begin
        abort_run("timeout: write address and data were never accepted");
      end
      @(negedge clk);
      #1;
      waited++;
    end
    exp_b.push_back(reference_access(1'b1, addr, data, strb));
    @(negedge clk);
    awvalid = 1'b0;
    wvalid = 1'b0;
  endtask

  task automatic send_read(input logic [31:0] addr);
    int waited;
    waited = 0;
    araddr = addr;
    arvalid = 1'b1;
    #1;
    while (!arready) begin
      if (waited == 200) begin
        abort_run("timeout: read address was never accepted");
      end
      @(negedge clk);
      #1;
      waited++;
    end
    exp_r.push_back(reference_access(1'b0, addr, 32'd0, 4'h0));
    @(negedge clk);
    arvalid = 1'b0;
  endtask

  task automatic wait_drain(input string name);
    int waited;
    waited = 0;
    while (exp_b.size() != 0 || exp_r.size() != 0) begin
      if (waited == 1000) begin
        abort_run({"timeout: responses still missing at the end of test ", name});
      end
      @(negedge clk);
      waited++;
    end
  endtask

  // response back-pressure, random only while stall is set
  initial begin
    integer rnd;
    bready = 1'b0;
    rready = 1'b0;
    ready_seed = 78892;
    forever begin
      @(negedge clk);
      rnd = $random(ready_seed);
      bready = stall ? rnd[0] : 1'b1;
      rready = stall ? rnd[1] : 1'b1;
    end
  end

  // compare every B and R beat that transfers on the next rising edge
  initial begin
    forever begin
      @(negedge clk);
      #1;
      if (rst_n && bvalid && bready) begin
        check_b_beat();
      end
      if (rst_n && rvalid && rready) begin
        check_r_beat();
      end
    end
  end

  initial begin
    int          mark;
    integer      rnd;
    logic [31:0] addr;
    logic [31:0] data;
    seed = 78892;
    stall = 1'b0;
    checks = 0;
    errors = 0;
    rst_n = 1'b0;
    awvalid = 1'b0;
    awaddr = 32'd0;
    wvalid = 1'b0;
    wdata = 32'd0;
    wstrb = 4'h0;
    arvalid = 1'b0;
    araddr = 32'd0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    mark = errors;
    @(negedge clk);
    check_word("bvalid", {31'd0, bvalid}, 32'd0);
    check_word("rvalid", {31'd0, rvalid}, 32'd0);
    check_word("awready", {31'd0, awready}, 32'd0);
    check_word("wready", {31'd0, wready}, 32'd0);
    check_word("arready", {31'd0, arready}, 32'd0);
    check_word("cmd_valid", {31'd0, uut.cmd_valid}, 32'd0);
    check_word("rsp_valid", {31'd0, uut.rsp_valid}, 32'd0);
    check_word("sram_we_n", {31'd0, sram_we_n}, 32'd1);
    check_word("sram_oe_n", {31'd0, sram_oe_n}, 32'd1);
    check_word("sram_ce_n", {31'd0, sram_ce_n}, 32'd0);
    report_test("reset state", mark);

    mark = errors;
    for (int i = 0; i < 256; i++) begin
      data = $random(seed);
      send_write({23'd0, i[7:0], 1'b0}, data, 4'hf);
    end
    for (int i = 0; i < 256; i++) begin
      send_read({23'd0, i[7:0], 1'b0});
    end
    wait_drain("write then read");
    report_test("write then read", mark);

    mark = errors;
    send_write(32'h20, 32'h0000_a5a5, 4'b0001);
    send_write(32'h20, 32'h0000_5a5a, 4'b0010);
    send_write(32'h20, 32'h0000_1234, 4'b1100);
    send_read(32'h20);
    wait_drain("strobe check");
    report_test("strobe check", mark);

    mark = errors;
    send_read(32'h200);
    send_write(32'h204, 32'hdead_beef, 4'hf);
    send_write(32'h8000_0000, 32'h0000_1111, 4'hf);
    send_read(32'h1_0004);
    send_read(32'h0);
    send_read(32'h4);
    send_read(32'h1fe);
    wait_drain("address range");
    report_test("address range", mark);

    // mixed traffic, some out of range and some with a partial strobe
    mark = errors;
    stall = 1'b1;
    for (int n = 0; n < 200; n++) begin
      rnd = $random(seed);
      addr = {23'd0, rnd[8:1], 1'b0};
      if (rnd[12:10] == 3'd0) begin
        addr[20] = 1'b1;
      end
      data = $random(seed);
      if (rnd[31]) begin
        send_write(addr, data, (rnd[15:13] == 3'd0) ? 4'b0111 : 4'hf);
      end else begin
        send_read(addr);
      end
    end
    wait_drain("back-pressure");
    stall = 1'b0;
    report_test("back-pressure", mark);

    mark = errors;
    for (int n = 0; n < 16; n++) begin
      rnd = $random(seed);
      addr = {23'd0, rnd[8:1], 1'b0};
      data = $random(seed);
      send_write(addr, data, 4'hf);
      send_read(addr);
    end
    wait_drain("write-read on one word");
    report_test("write-read on one word", mark);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
logic/sram_pkg.sv
logic/axil_sram_bridge.sv
logic/sram_meta_fifo.sv
logic/sram_cmd_ctrl.sv
logic/sram_pad_io.sv
logic/sram_axil_top.sv
sim/async_sram_model.sv
sim/tb_sram_axil.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_sram_axil
FILELIST  := sim.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG) || ! grep -q "TESTS PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
